// ==== source/scope_cmd_pkg.sv ====
`default_nettype none

package scope_cmd_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic signed [11:0] thresh_t;
	typedef logic [15:0] length_t;
	typedef logic [7:0] acq_state_t;
	typedef logic [19:0] sample_idx_t;
	typedef logic [2:0] chip_sel_t;
	typedef logic [4:0] downsample_t;

	typedef enum logic [7:0] {
		CMD_ARM        = 8'd1,
		CMD_SPI        = 8'd3,
		CMD_THRESH     = 8'd8,
		CMD_DOWNSAMPLE = 8'd9,
		CMD_STATUS     = 8'd12,
		CMD_READ_REG   = 8'd14
	} cmd_code_t;

	typedef enum logic [1:0] {IDLE, WAIT_SPI, RESPOND} disp_state_t;

	typedef enum logic [2:0] {CS_SETUP, SEND, WAIT_RX, CS_HOLD, DONE} spi_state_t;

	localparam int FRAME_BYTES = 8;
	localparam word_t FW_VERSION = 32'd25;

	localparam acq_state_t ACQ_IDLE = 8'd0; // triggerer waiting
	localparam acq_state_t ACQ_DONE = 8'd249; // event read out

	localparam thresh_t THRESH_MID = 12'sd128; // adc mid-scale
	localparam int THRESH_SHIFT = 4;
	localparam thresh_t THRESH_ROUND = 12'sd8; // half lsb after shift

	localparam int CS_SETUP_CYCLES = 10;
	localparam int CS_HOLD_CYCLES = 35;
	localparam int NUM_CHIPS = 8;

	// read-register indices
	localparam byte_t REG_VERSION      = 8'd0;
	localparam byte_t REG_ACQ_STATE    = 8'd1;
	localparam byte_t REG_EVENT_COUNT  = 8'd2;
	localparam byte_t REG_SAMPLE_TRIG  = 8'd3;
	localparam byte_t REG_DOWNSAMPLE   = 8'd4;
	localparam byte_t REG_HIGHRES      = 8'd5;
	localparam byte_t REG_MERGING      = 8'd6;
	localparam byte_t REG_UPPER_THRESH = 8'd7;
	localparam byte_t REG_LOWER_THRESH = 8'd8;

endpackage

`default_nettype wire

// ==== source/cmd_frame_rx.sv ====
`default_nettype none

module cmd_frame_rx import scope_cmd_pkg::*; (
	input  wire   clk,
	input  wire   rstn,
	input  wire   i_rx_valid,
	input  byte_t i_rx_data,
	output logic  o_rx_ready,
	input  wire   i_frame_ready,
	output logic  o_frame_valid,
	output byte_t o_frame_b0,
	output byte_t o_frame_b1,
	output byte_t o_frame_b2,
	output byte_t o_frame_b3,
	output byte_t o_frame_b4,
	output byte_t o_frame_b5,
	output byte_t o_frame_b6,
	output byte_t o_frame_b7
);

	byte_t      frame_q [FRAME_BYTES];
	logic [2:0] byte_cnt; // next slot to fill
	logic       rx_take;

	assign o_rx_ready = !o_frame_valid; // stall host while frame pending
	assign rx_take = i_rx_valid && o_rx_ready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt <= '0;
			o_frame_valid <= 1'b0;
		end else begin
			if (rx_take) begin
				byte_cnt <= byte_cnt + 3'd1; // wraps after last byte
				if (byte_cnt == 3'(FRAME_BYTES - 1))
					o_frame_valid <= 1'b1;
			end else if (o_frame_valid && i_frame_ready) begin
				o_frame_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_take)
			frame_q[byte_cnt] <= i_rx_data;
	end

	assign o_frame_b0 = frame_q[0]; // command code
	assign o_frame_b1 = frame_q[1];
	assign o_frame_b2 = frame_q[2];
	assign o_frame_b3 = frame_q[3];
	assign o_frame_b4 = frame_q[4];
	assign o_frame_b5 = frame_q[5];
	assign o_frame_b6 = frame_q[6];
	assign o_frame_b7 = frame_q[7];

endmodule

`default_nettype wire

// ==== source/cmd_dispatch.sv ====
`default_nettype none

module cmd_dispatch import scope_cmd_pkg::*; (
	input  wire         clk,
	input  wire         rstn,
	input  wire         i_frame_valid,
	output logic        o_frame_ready,
	input  byte_t       i_frame_b0,
	input  byte_t       i_frame_b1,
	input  byte_t       i_frame_b2,
	input  byte_t       i_frame_b3,
	input  byte_t       i_frame_b4,
	input  byte_t       i_frame_b5,
	input  byte_t       i_frame_b6,
	input  byte_t       i_frame_b7,
	input  acq_state_t  i_acq_state,
	input  word_t       i_event_count,
	input  sample_idx_t i_sample_triggered,
	output logic        o_resp_valid,
	input  wire         i_resp_ready,
	output word_t       o_resp_word,
	output logic        o_spi_start,
	output chip_sel_t   o_spi_chip,
	output byte_t       o_spi_nbytes,
	output byte_t       o_spi_b1,
	output byte_t       o_spi_b2,
	output byte_t       o_spi_b3,
	output byte_t       o_spi_b4,
	input  wire         i_spi_done,
	input  word_t       i_spi_rd_word,
	output byte_t       o_trigger_type,
	output byte_t       o_channel_type,
	output length_t     o_length_to_take,
	output logic        o_trigger_live,
	output thresh_t     o_lower_thresh,
	output thresh_t     o_upper_thresh,
	output logic [9:0]  o_ram_preoffset,
	output byte_t       o_trigger_tot,
	output logic        o_trigger_chan,
	output downsample_t o_downsample,
	output logic        o_highres,
	output byte_t       o_downsample_merging
);

	disp_state_t state;
	acq_state_t  acq_sync;
	word_t       event_sync;
	sample_idx_t sample_sync;
	word_t       status_word;
	word_t       reg_rd_val;
	thresh_t     lower_calc;
	thresh_t     upper_calc;

	// triggerer values, one register stage
	always_ff @(posedge clk) begin
		acq_sync <= i_acq_state;
		event_sync <= i_event_count;
		sample_sync <= i_sample_triggered;
	end

	assign o_frame_ready = (state == IDLE);
	assign status_word = {4'd0, sample_sync, acq_sync};

	// level in b1, hysteresis in b2
	assign lower_calc = (({4'd0, i_frame_b1} - {4'd0, i_frame_b2} - THRESH_MID) << THRESH_SHIFT)
		+ THRESH_ROUND;
	assign upper_calc = (({4'd0, i_frame_b1} + {4'd0, i_frame_b2} - THRESH_MID) << THRESH_SHIFT)
		+ THRESH_ROUND;

	always_comb begin
		case (i_frame_b1)
			REG_VERSION:      reg_rd_val = FW_VERSION;
			REG_ACQ_STATE:    reg_rd_val = {24'd0, acq_sync};
			REG_EVENT_COUNT:  reg_rd_val = event_sync;
			REG_SAMPLE_TRIG:  reg_rd_val = {12'd0, sample_sync};
			REG_DOWNSAMPLE:   reg_rd_val = {27'd0, o_downsample};
			REG_HIGHRES:      reg_rd_val = {31'd0, o_highres};
			REG_MERGING:      reg_rd_val = {24'd0, o_downsample_merging};
			REG_UPPER_THRESH: reg_rd_val = {20'd0, o_upper_thresh};
			REG_LOWER_THRESH: reg_rd_val = {20'd0, o_lower_thresh};
			default:          reg_rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
			o_resp_valid <= 1'b0;
			o_resp_word <= '0;
			o_spi_start <= 1'b0;
			o_spi_chip <= '0;
			o_spi_nbytes <= '0;
			o_spi_b1 <= '0;
			o_spi_b2 <= '0;
			o_spi_b3 <= '0;
			o_spi_b4 <= '0;
			o_trigger_type <= '0;
			o_channel_type <= '0;
			o_length_to_take <= '0;
			o_trigger_live <= 1'b0;
			o_lower_thresh <= '0;
			o_upper_thresh <= '0;
			o_ram_preoffset <= '0;
			o_trigger_tot <= '0;
			o_trigger_chan <= 1'b0;
			o_downsample <= '0;
			o_highres <= 1'b0;
			o_downsample_merging <= '0;
		end else begin
			o_spi_start <= 1'b0; // single-cycle strobe
			case (state)
				IDLE: begin
					if (i_frame_valid) begin
						case (i_frame_b0)
							CMD_ARM: begin
								o_trigger_type <= i_frame_b1;
								o_channel_type <= i_frame_b2;
								o_length_to_take <= {i_frame_b5, i_frame_b4};
								if (acq_sync == ACQ_IDLE || acq_sync == ACQ_DONE)
									o_trigger_live <= 1'b1; // only re-arm when idle
								o_resp_word <= status_word;
								o_resp_valid <= 1'b1;
								state <= RESPOND;
							end
							CMD_SPI: begin
								o_spi_chip <= i_frame_b1[2:0];
								o_spi_nbytes <= i_frame_b7;
								o_spi_b1 <= i_frame_b2;
								o_spi_b2 <= i_frame_b3;
								o_spi_b3 <= i_frame_b4;
								o_spi_b4 <= i_frame_b5;
								o_spi_start <= 1'b1;
								state <= WAIT_SPI;
							end
							CMD_THRESH: begin
								o_lower_thresh <= lower_calc;
								o_upper_thresh <= upper_calc;
								o_ram_preoffset <= {i_frame_b3[1:0], i_frame_b4};
								o_trigger_tot <= i_frame_b5;
								o_trigger_chan <= i_frame_b6[0];
								o_resp_word <= 32'd8;
								o_resp_valid <= 1'b1;
								state <= RESPOND;
							end
							CMD_DOWNSAMPLE: begin
								o_downsample <= i_frame_b1[4:0];
								o_highres <= i_frame_b2[0];
								o_downsample_merging <= i_frame_b3;
								o_resp_word <= 32'd9;
								o_resp_valid <= 1'b1;
								state <= RESPOND;
							end
							CMD_STATUS: begin
								o_resp_word <= status_word;
								o_resp_valid <= 1'b1;
								state <= RESPOND;
							end
							CMD_READ_REG: begin
								o_resp_word <= reg_rd_val;
								o_resp_valid <= 1'b1;
								state <= RESPOND;
							end
							default: begin
								state <= IDLE; // unknown code, frame dropped
							end
						endcase
					end
				end
				WAIT_SPI: begin
					if (i_spi_done) begin
						o_resp_word <= i_spi_rd_word;
						o_resp_valid <= 1'b1;
						state <= RESPOND;
					end
				end
				RESPOND: begin
					if (i_resp_ready) begin
						o_resp_valid <= 1'b0;
						o_trigger_live <= 1'b0; // live only until host has the reply
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/spi_transfer_seq.sv ====
`default_nettype none

module spi_transfer_seq import scope_cmd_pkg::*; (
	input  wire                  clk,
	input  wire                  rstn,
	input  wire                  i_start,
	input  chip_sel_t            i_chip,
	input  byte_t                i_nbytes,
	input  byte_t                i_b1,
	input  byte_t                i_b2,
	input  byte_t                i_b3,
	input  byte_t                i_b4,
	output byte_t                o_spi_tx,
	output logic                 o_spi_tx_dv,
	input  wire                  i_spi_tx_ready,
	input  wire                  i_spi_rx_dv,
	input  byte_t                i_spi_rx,
	output logic [NUM_CHIPS-1:0] o_spi_cs,
	output chip_sel_t            o_miso_sel,
	output logic                 o_done,
	output word_t                o_rd_word
);

	spi_state_t state;
	logic [5:0] wait_cnt; // cs setup and hold timer
	logic [1:0] byte_idx;
	logic [1:0] last_idx;
	byte_t      tx_bytes [4];
	byte_t      rd_hi;
	byte_t      rd_lo;
	logic       start_ok;
	logic       rx_take;

	assign start_ok = (state == DONE) && i_start;
	assign rx_take = (state == WAIT_RX) && i_spi_rx_dv;

	assign o_spi_tx = tx_bytes[byte_idx];
	assign o_rd_word = {16'd0, rd_hi, rd_lo};

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= DONE; // rests here between transactions
			wait_cnt <= '0;
			byte_idx <= '0;
			last_idx <= '0;
			o_spi_tx_dv <= 1'b0;
			o_spi_cs <= '1;
			o_miso_sel <= '0;
			o_done <= 1'b0;
		end else begin
			o_spi_tx_dv <= 1'b0;
			o_done <= 1'b0;
			case (state)
				DONE: begin
					if (start_ok) begin
						o_spi_cs <= ~(NUM_CHIPS'(1) << i_chip); // select one chip
						o_miso_sel <= i_chip;
						byte_idx <= '0;
						wait_cnt <= '0;
						// 2 or 4 bytes on request, 3 otherwise
						if (i_nbytes == 8'd2)
							last_idx <= 2'd1;
						else if (i_nbytes == 8'd4)
							last_idx <= 2'd3;
						else
							last_idx <= 2'd2;
						state <= CS_SETUP;
					end
				end
				CS_SETUP: begin
					if (wait_cnt == 6'(CS_SETUP_CYCLES - 1)) begin
						wait_cnt <= '0;
						state <= SEND;
					end else begin
						wait_cnt <= wait_cnt + 6'd1;
					end
				end
				SEND: begin
					if (i_spi_tx_ready) begin
						o_spi_tx_dv <= 1'b1;
						state <= WAIT_RX;
					end
				end
				WAIT_RX: begin
					if (i_spi_rx_dv) begin
						if (byte_idx == last_idx) begin
							state <= CS_HOLD;
						end else begin
							byte_idx <= byte_idx + 2'd1;
							state <= SEND;
						end
					end
				end
				CS_HOLD: begin
					if (wait_cnt == 6'(CS_HOLD_CYCLES - 1)) begin
						wait_cnt <= '0;
						o_spi_cs <= '1;
						o_done <= 1'b1;
						state <= DONE;
					end else begin
						wait_cnt <= wait_cnt + 6'd1;
					end
				end
				default: state <= DONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			tx_bytes[0] <= i_b1;
			tx_bytes[1] <= i_b2;
			tx_bytes[2] <= i_b3;
			tx_bytes[3] <= i_b4;
		end
		if (rx_take && byte_idx == 2'd1)
			rd_hi <= i_spi_rx; // read data of second byte
		if (rx_take && byte_idx == last_idx)
			rd_lo <= i_spi_rx;
	end

endmodule

`default_nettype wire

// ==== source/resp_word_tx.sv ====
`default_nettype none

module resp_word_tx import scope_cmd_pkg::*; (
	input  wire        clk,
	input  wire        rstn,
	input  wire        i_resp_valid,
	output logic       o_resp_ready,
	input  word_t      i_resp_word,
	output logic       o_tx_valid,
	input  wire        i_tx_ready,
	output word_t      o_tx_data,
	output logic [3:0] o_tx_keep,
	output logic       o_tx_last
);

	logic load;

	// empty, or current word leaving this cycle
	assign o_resp_ready = !o_tx_valid || i_tx_ready;
	assign load = i_resp_valid && o_resp_ready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tx_valid <= 1'b0;
		end else if (load) begin
			o_tx_valid <= 1'b1;
		end else if (i_tx_ready) begin
			o_tx_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			o_tx_data <= i_resp_word;
	end

	assign o_tx_keep = 4'b1111; // every reply is one full word
	assign o_tx_last = 1'b1;

endmodule

`default_nettype wire

// ==== source/scope_cmd_top.sv ====
`default_nettype none

module scope_cmd_top import scope_cmd_pkg::*; (
	input  wire                  clk,
	input  wire                  rstn,
	// host command stream
	input  wire                  i_rx_valid,
	input  byte_t                i_rx_data,
	output logic                 o_rx_ready,
	// response stream
	output logic                 o_tx_valid,
	input  wire                  i_tx_ready,
	output word_t                o_tx_data,
	output logic [3:0]           o_tx_keep,
	output logic                 o_tx_last,
	// spi byte engine
	output byte_t                o_spi_tx,
	output logic                 o_spi_tx_dv,
	input  wire                  i_spi_tx_ready,
	input  wire                  i_spi_rx_dv,
	input  byte_t                i_spi_rx,
	output logic [NUM_CHIPS-1:0] o_spi_cs,
	output chip_sel_t            o_miso_sel,
	// triggerer
	input  acq_state_t           i_acq_state,
	input  word_t                i_event_count,
	input  sample_idx_t          i_sample_triggered,
	output byte_t                o_trigger_type,
	output byte_t                o_channel_type,
	output length_t              o_length_to_take,
	output logic                 o_trigger_live,
	output thresh_t              o_lower_thresh,
	output thresh_t              o_upper_thresh,
	output logic [9:0]           o_ram_preoffset,
	output byte_t                o_trigger_tot,
	output logic                 o_trigger_chan,
	output downsample_t          o_downsample,
	output logic                 o_highres,
	output byte_t                o_downsample_merging
);

	logic      frame_valid;
	logic      frame_ready;
	byte_t     frame_b0;
	byte_t     frame_b1;
	byte_t     frame_b2;
	byte_t     frame_b3;
	byte_t     frame_b4;
	byte_t     frame_b5;
	byte_t     frame_b6;
	byte_t     frame_b7;
	logic      resp_valid;
	logic      resp_ready;
	word_t     resp_word;
	logic      spi_start;
	chip_sel_t spi_chip;
	byte_t     spi_nbytes;
	byte_t     spi_b1;
	byte_t     spi_b2;
	byte_t     spi_b3;
	byte_t     spi_b4;
	logic      spi_done;
	word_t     spi_rd_word;

	cmd_frame_rx cmd_frame_rx_inst (
		.clk           (clk),
		.rstn          (rstn),
		.i_rx_valid    (i_rx_valid),
		.i_rx_data     (i_rx_data),
		.o_rx_ready    (o_rx_ready),
		.i_frame_ready (frame_ready),
		.o_frame_valid (frame_valid),
		.o_frame_b0    (frame_b0),
		.o_frame_b1    (frame_b1),
		.o_frame_b2    (frame_b2),
		.o_frame_b3    (frame_b3),
		.o_frame_b4    (frame_b4),
		.o_frame_b5    (frame_b5),
		.o_frame_b6    (frame_b6),
		.o_frame_b7    (frame_b7)
	);

	cmd_dispatch cmd_dispatch_inst (
		.clk                  (clk),
		.rstn                 (rstn),
		.i_frame_valid        (frame_valid),
		.o_frame_ready        (frame_ready),
		.i_frame_b0           (frame_b0),
		.i_frame_b1           (frame_b1),
		.i_frame_b2           (frame_b2),
		.i_frame_b3           (frame_b3),
		.i_frame_b4           (frame_b4),
		.i_frame_b5           (frame_b5),
		.i_frame_b6           (frame_b6),
		.i_frame_b7           (frame_b7),
		.i_acq_state          (i_acq_state),
		.i_event_count        (i_event_count),
		.i_sample_triggered   (i_sample_triggered),
		.o_resp_valid         (resp_valid),
		.i_resp_ready         (resp_ready),
		.o_resp_word          (resp_word),
		.o_spi_start          (spi_start),
		.o_spi_chip           (spi_chip),
		.o_spi_nbytes         (spi_nbytes),
		.o_spi_b1             (spi_b1),
		.o_spi_b2             (spi_b2),
		.o_spi_b3             (spi_b3),
		.o_spi_b4             (spi_b4),
		.i_spi_done           (spi_done),
		.i_spi_rd_word        (spi_rd_word),
		.o_trigger_type       (o_trigger_type),
		.o_channel_type       (o_channel_type),
		.o_length_to_take     (o_length_to_take),
		.o_trigger_live       (o_trigger_live),
		.o_lower_thresh       (o_lower_thresh),
		.o_upper_thresh       (o_upper_thresh),
		.o_ram_preoffset      (o_ram_preoffset),
		.o_trigger_tot        (o_trigger_tot),
		.o_trigger_chan       (o_trigger_chan),
		.o_downsample         (o_downsample),
		.o_highres            (o_highres),
		.o_downsample_merging (o_downsample_merging)
	);

	spi_transfer_seq spi_transfer_seq_inst (
		.clk            (clk),
		.rstn           (rstn),
		.i_start        (spi_start),
		.i_chip         (spi_chip),
		.i_nbytes       (spi_nbytes),
		.i_b1           (spi_b1),
		.i_b2           (spi_b2),
		.i_b3           (spi_b3),
		.i_b4           (spi_b4),
		.o_spi_tx       (o_spi_tx),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx       (i_spi_rx),
		.o_spi_cs       (o_spi_cs),
		.o_miso_sel     (o_miso_sel),
		.o_done         (spi_done),
		.o_rd_word      (spi_rd_word)
	);

	resp_word_tx resp_word_tx_inst (
		.clk          (clk),
		.rstn         (rstn),
		.i_resp_valid (resp_valid),
		.o_resp_ready (resp_ready),
		.i_resp_word  (resp_word),
		.o_tx_valid   (o_tx_valid),
		.i_tx_ready   (i_tx_ready),
		.o_tx_data    (o_tx_data),
		.o_tx_keep    (o_tx_keep),
		.o_tx_last    (o_tx_last)
	);

endmodule

`default_nettype wire

// ==== verification/tb_scope_cmd_top.sv ====
`default_nettype none

module tb_scope_cmd_top;

	localparam logic [19:0] SAMPLE_IDX = 20'h5_3c2a; // triggerer sample index
	localparam logic [31:0] EVENT_CNT = 32'h0001_2345;
	localparam int BYTE_TIMEOUT = 50;
	localparam int RESP_TIMEOUT = 300; // longest spi transaction is well inside

	logic        clk;
	logic        rstn;
	logic        i_rx_valid;
	logic [7:0]  i_rx_data;
	logic        o_rx_ready;
	logic        o_tx_valid;
	logic        i_tx_ready;
	logic [31:0] o_tx_data;
	logic [3:0]  o_tx_keep;
	logic        o_tx_last;
	logic [7:0]  o_spi_tx;
	logic        o_spi_tx_dv;
	logic        i_spi_tx_ready;
	logic        i_spi_rx_dv;
	logic [7:0]  i_spi_rx;
	logic [7:0]  o_spi_cs;
	logic [2:0]  o_miso_sel;
	logic [7:0]  i_acq_state;
	logic [31:0] i_event_count;
	logic [19:0] i_sample_triggered;
	logic [7:0]  o_trigger_type;
	logic [7:0]  o_channel_type;
	logic [15:0] o_length_to_take;
	logic        o_trigger_live;
	logic [11:0] o_lower_thresh;
	logic [11:0] o_upper_thresh;
	logic [9:0]  o_ram_preoffset;
	logic [7:0]  o_trigger_tot;
	logic        o_trigger_chan;
	logic [4:0]  o_downsample;
	logic        o_highres;
	logic [7:0]  o_downsample_merging;

	int          mismatch_count;
	int          fail_count;
	int          spi_tx_count; // bytes seen by the spi model this row
	logic [7:0]  spi_cs_exp;

	// stimulus table, one entry per command
	logic [63:0] tbl_frame [$];
	logic [7:0]  tbl_acq [$];
	logic [31:0] tbl_exp [$];
	bit          tbl_noresp [$];
	bit          tbl_live [$];

	scope_cmd_top scope_cmd_top_inst (
		.clk                  (clk),
		.rstn                 (rstn),
		.i_rx_valid           (i_rx_valid),
		.i_rx_data            (i_rx_data),
		.o_rx_ready           (o_rx_ready),
		.o_tx_valid           (o_tx_valid),
		.i_tx_ready           (i_tx_ready),
		.o_tx_data            (o_tx_data),
		.o_tx_keep            (o_tx_keep),
		.o_tx_last            (o_tx_last),
		.o_spi_tx             (o_spi_tx),
		.o_spi_tx_dv          (o_spi_tx_dv),
		.i_spi_tx_ready       (i_spi_tx_ready),
		.i_spi_rx_dv          (i_spi_rx_dv),
		.i_spi_rx             (i_spi_rx),
		.o_spi_cs             (o_spi_cs),
		.o_miso_sel           (o_miso_sel),
		.i_acq_state          (i_acq_state),
		.i_event_count        (i_event_count),
		.i_sample_triggered   (i_sample_triggered),
		.o_trigger_type       (o_trigger_type),
		.o_channel_type       (o_channel_type),
		.o_length_to_take     (o_length_to_take),
		.o_trigger_live       (o_trigger_live),
		.o_lower_thresh       (o_lower_thresh),
		.o_upper_thresh       (o_upper_thresh),
		.o_ram_preoffset      (o_ram_preoffset),
		.o_trigger_tot        (o_trigger_tot),
		.o_trigger_chan       (o_trigger_chan),
		.o_downsample         (o_downsample),
		.o_highres            (o_highres),
		.o_downsample_merging (o_downsample_merging)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// spi byte engine model, echoes each byte xor a5
	initial begin
		logic [7:0] echo;
		i_spi_tx_ready = 1'b1;
		i_spi_rx_dv = 1'b0;
		i_spi_rx = 8'h00;
		forever begin
			@(posedge clk);
			#2;
			if (o_spi_tx_dv) begin
				echo = o_spi_tx ^ 8'hA5;
				spi_tx_count++;
				if (o_spi_cs !== spi_cs_exp) begin
					$display("mismatch at %0t: spi cs %h during transfer, expected %h",
						$time, o_spi_cs, spi_cs_exp);
					mismatch_count++;
				end
				i_spi_tx_ready = 1'b0; // busy shifting
				repeat (3) @(posedge clk);
				#2;
				i_spi_rx_dv = 1'b1;
				i_spi_rx = echo;
				@(posedge clk);
				#2;
				i_spi_rx_dv = 1'b0;
				i_spi_tx_ready = 1'b1;
			end
		end
	end

	task automatic step_clk();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [63:0] make_frame(input logic [7:0] b0, input logic [7:0] b1,
		input logic [7:0] b2, input logic [7:0] b3, input logic [7:0] b4, input logic [7:0] b5,
		input logic [7:0] b6, input logic [7:0] b7);
		return {b7, b6, b5, b4, b3, b2, b1, b0}; // b0 in the low byte
	endfunction

	function automatic logic [7:0] frame_byte(input logic [63:0] frame, input int idx);
		return frame[8*idx +: 8];
	endfunction

	// ((level -/+ hyst - 128) * 16) + 8, kept to 12 bits
	function automatic logic [11:0] thresh_expect(input logic [7:0] level,
		input logic [7:0] hyst, input bit upper);
		int v;
		if (upper)
			v = int'(level) + int'(hyst) - 128;
		else
			v = int'(level) - int'(hyst) - 128;
		v = v * 16 + 8;
		return v[11:0];
	endfunction

	function automatic logic [31:0] status_expect(input logic [7:0] acq);
		return {4'd0, SAMPLE_IDX, acq};
	endfunction

	// second rx byte in 15:8, last rx byte in 7:0
	function automatic logic [31:0] spi_expect(input logic [63:0] frame);
		logic [7:0] nbytes;
		logic [7:0] last_tx;
		nbytes = frame_byte(frame, 7);
		if (nbytes == 8'd2)
			last_tx = frame_byte(frame, 3);
		else if (nbytes == 8'd4)
			last_tx = frame_byte(frame, 5);
		else
			last_tx = frame_byte(frame, 4);
		return {16'd0, frame_byte(frame, 3) ^ 8'hA5, last_tx ^ 8'hA5};
	endfunction

	task automatic add_row(input logic [63:0] frame, input logic [7:0] acq,
		input logic [31:0] exp_word, input bit no_resp, input bit live);
		tbl_frame.push_back(frame);
		tbl_acq.push_back(acq);
		tbl_exp.push_back(exp_word);
		tbl_noresp.push_back(no_resp);
		tbl_live.push_back(live);
	endtask

	task automatic send_frame(input int row, input logic [63:0] frame);
		int  i;
		int  cyc;
		bit  taken;
		for (i = 0; i < 8; i++) begin
			i_rx_valid = 1'b1;
			i_rx_data = frame_byte(frame, i);
			taken = 1'b0;
			cyc = 0;
			while (!taken && cyc < BYTE_TIMEOUT) begin
				taken = o_rx_ready; // holds until the next edge
				step_clk();
				cyc++;
			end
			if (!taken) begin
				$display("row %0d: timed out sending frame byte %0d", row, i);
				fail_count++;
				i_rx_valid = 1'b0;
				return;
			end
		end
		i_rx_valid = 1'b0;
	endtask

	task automatic collect_response(input int row, input bit none_expected, output bit got,
		output logic [31:0] word, output logic [3:0] keep, output logic last,
		output bit live_seen);
		int cyc;
		bit seen;
		got = 1'b0;
		seen = 1'b0;
		live_seen = 1'b0;
		word = '0;
		keep = '0;
		last = 1'b0;
		cyc = 0;
		while (!got && cyc < RESP_TIMEOUT) begin
			i_tx_ready = ($urandom % 3) != 0; // host stalls about one cycle in three
			if (o_trigger_live)
				live_seen = 1'b1;
			if (o_tx_valid) begin
				if (!seen) begin
					seen = 1'b1;
					word = o_tx_data;
					keep = o_tx_keep;
					last = o_tx_last;
				end else if (o_tx_data !== word) begin
					$display("mismatch at %0t: row %0d word changed from %h to %h while stalled",
						$time, row, word, o_tx_data);
					mismatch_count++;
				end
				if (i_tx_ready)
					got = 1'b1;
			end
			step_clk();
			cyc++;
		end
		i_tx_ready = 1'b0;
		if (none_expected && seen) begin
			$display("row %0d: a response came for a command that should give none", row);
			fail_count++;
		end else if (!none_expected && !got) begin
			$display("row %0d: timed out waiting for the response", row);
			fail_count++;
		end
	endtask

	// second reply waits behind a stalled one and replaces it on the accept edge
	task automatic check_queued_reply(input int row);
		int cyc;
		i_tx_ready = 1'b0;
		send_frame(row, make_frame(8'd14, 8'd0, 0, 0, 0, 0, 0, 0)); // version, 25
		cyc = 0;
		while (o_tx_valid !== 1'b1 && cyc < RESP_TIMEOUT) begin
			step_clk();
			cyc++;
		end
		if (o_tx_valid !== 1'b1) begin
			$display("row %0d: timed out waiting for the stalled response", row);
			fail_count++;
			return;
		end
		send_frame(row, make_frame(8'd14, 8'd6, 0, 0, 0, 0, 0, 0)); // merging, 5a
		repeat (4) begin
			if (o_tx_valid !== 1'b1 || o_tx_data !== 32'd25) begin
				$display("mismatch at %0t: row %0d stalled word %h valid %b, expected 25",
					$time, row, o_tx_data, o_tx_valid);
				mismatch_count++;
			end
			step_clk();
		end
		i_tx_ready = 1'b1;
		step_clk();
		i_tx_ready = 1'b0;
		if (o_tx_valid !== 1'b1 || o_tx_data !== 32'h5A) begin
			$display("mismatch at %0t: row %0d queued word %h valid %b, expected 5a",
				$time, row, o_tx_data, o_tx_valid);
			mismatch_count++;
		end
		i_tx_ready = 1'b1;
		step_clk();
		i_tx_ready = 1'b0;
		if (o_tx_valid !== 1'b0) begin
			$display("mismatch at %0t: row %0d tx valid still high after both replies",
				$time, row);
			mismatch_count++;
		end
	endtask

	task automatic check_settings(input int row, input logic [63:0] frame);
		logic [7:0] b [8];
		int         i;
		for (i = 0; i < 8; i++)
			b[i] = frame_byte(frame, i);
		case (b[0])
			8'd1: begin
				if (o_trigger_type !== b[1] || o_channel_type !== b[2]
					|| o_length_to_take !== {b[5], b[4]}) begin
					$display("mismatch at %0t: row %0d arm settings %h %h %h", $time, row,
						o_trigger_type, o_channel_type, o_length_to_take);
					mismatch_count++;
				end
			end
			8'd8: begin
				if (o_lower_thresh !== thresh_expect(b[1], b[2], 1'b0)
					|| o_upper_thresh !== thresh_expect(b[1], b[2], 1'b1)) begin
					$display("mismatch at %0t: row %0d thresholds %h %h", $time, row,
						o_lower_thresh, o_upper_thresh);
					mismatch_count++;
				end
				if (o_ram_preoffset !== {b[3][1:0], b[4]} || o_trigger_tot !== b[5]
					|| o_trigger_chan !== b[6][0]) begin
					$display("mismatch at %0t: row %0d preoffset/tot/chan %h %h %b", $time, row,
						o_ram_preoffset, o_trigger_tot, o_trigger_chan);
					mismatch_count++;
				end
			end
			8'd9: begin
				if (o_downsample !== b[1][4:0] || o_highres !== b[2][0]
					|| o_downsample_merging !== b[3]) begin
					$display("mismatch at %0t: row %0d downsample settings %h %b %h", $time, row,
						o_downsample, o_highres, o_downsample_merging);
					mismatch_count++;
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		int          r;
		int          seed_init;
		int          exp_count;
		logic [63:0] frame;
		logic [7:0]  chip;
		bit          got;
		bit          live_seen;
		logic [31:0] word;
		logic [3:0]  keep;
		logic        last;

		seed_init = $urandom(32'h600b_22f0);
		mismatch_count = 0;
		fail_count = 0;
		spi_tx_count = 0;
		spi_cs_exp = 8'hFF;
		rstn = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_data = 8'h00;
		i_tx_ready = 1'b0;
		i_acq_state = 8'd0;
		i_event_count = EVENT_CNT;
		i_sample_triggered = SAMPLE_IDX;

		add_row(make_frame(8'd8, 8'h90, 8'h10, 8'h02, 8'h34, 8'h06, 8'h01, 8'h00),
			8'd0, 32'd8, 1'b0, 1'b0);
		add_row(make_frame(8'd8, 8'h20, 8'h30, 8'h01, 8'hAB, 8'h0C, 8'h00, 8'h00),
			8'd0, 32'd8, 1'b0, 1'b0); // negative thresholds
		add_row(make_frame(8'd14, 8'd7, 0, 0, 0, 0, 0, 0), 8'd0,
			{20'd0, thresh_expect(8'h20, 8'h30, 1'b1)}, 1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd8, 0, 0, 0, 0, 0, 0), 8'd0,
			{20'd0, thresh_expect(8'h20, 8'h30, 1'b0)}, 1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd0, 0, 0, 0, 0, 0, 0), 8'd0, 32'd25, 1'b0, 1'b0);
		add_row(make_frame(8'd9, 8'hE6, 8'h03, 8'h5A, 0, 0, 0, 0), 8'd0, 32'd9, 1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd4, 0, 0, 0, 0, 0, 0), 8'd0, 32'd6, 1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd5, 0, 0, 0, 0, 0, 0), 8'd0, 32'd1, 1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd6, 0, 0, 0, 0, 0, 0), 8'd0, 32'h5A, 1'b0, 1'b0);
		add_row(make_frame(8'd1, 8'h02, 8'h01, 0, 8'h00, 8'h10, 0, 0), 8'd0,
			status_expect(8'd0), 1'b0, 1'b1);
		add_row(make_frame(8'd1, 8'h03, 8'h02, 0, 8'h80, 8'h01, 0, 0), 8'd5,
			status_expect(8'd5), 1'b0, 1'b0); // busy, no re-arm
		add_row(make_frame(8'd1, 8'h01, 8'h00, 0, 8'h40, 8'h00, 0, 0), 8'd249,
			status_expect(8'd249), 1'b0, 1'b1);
		add_row(make_frame(8'd12, 0, 0, 0, 0, 0, 0, 0), 8'd5, status_expect(8'd5), 1'b0, 1'b0);
		frame = make_frame(8'd3, 8'd3, 8'h81, 8'h42, 8'h00, 8'h00, 8'h00, 8'd2);
		add_row(frame, 8'd5, spi_expect(frame), 1'b0, 1'b0);
		frame = make_frame(8'd3, 8'd3, 8'h01, 8'h3C, 8'h77, 8'hC8, 8'h00, 8'd4);
		add_row(frame, 8'd5, spi_expect(frame), 1'b0, 1'b0);
		frame = make_frame(8'd3, 8'd5, 8'h9F, 8'h10, 8'hE3, 8'h00, 8'h00, 8'd3);
		add_row(frame, 8'd5, spi_expect(frame), 1'b0, 1'b0);
		add_row(make_frame(8'd7, 8'h11, 8'h22, 0, 0, 0, 0, 0), 8'd5, 32'd0, 1'b1, 1'b0);
		add_row(make_frame(8'd14, 8'd2, 0, 0, 0, 0, 0, 0), 8'd5, EVENT_CNT, 1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd3, 0, 0, 0, 0, 0, 0), 8'd5, {12'd0, SAMPLE_IDX},
			1'b0, 1'b0);
		add_row(make_frame(8'd14, 8'd9, 0, 0, 0, 0, 0, 0), 8'd5, 32'd0, 1'b0, 1'b0);

		repeat (2) @(posedge clk);
		#2;
		rstn = 1'b1;

		// state straight after reset
		if (o_tx_valid !== 1'b0 || o_trigger_live !== 1'b0) begin
			$display("mismatch at %0t: tx_valid %b trigger_live %b after reset",
				$time, o_tx_valid, o_trigger_live);
			mismatch_count++;
		end
		if (o_spi_cs !== 8'hFF || o_rx_ready !== 1'b1) begin
			$display("mismatch at %0t: spi cs %h rx_ready %b after reset",
				$time, o_spi_cs, o_rx_ready);
			mismatch_count++;
		end
		if (o_lower_thresh !== 12'd0 || o_upper_thresh !== 12'd0 || o_downsample !== 5'd0
			|| o_length_to_take !== 16'd0) begin
			$display("mismatch at %0t: settings not zero after reset", $time);
			mismatch_count++;
		end
		step_clk();

		for (r = 0; r < tbl_frame.size(); r++) begin
			frame = tbl_frame[r];
			chip = frame_byte(frame, 1);
			i_acq_state = tbl_acq[r];
			spi_tx_count = 0;
			if (frame_byte(frame, 0) == 8'd3)
				spi_cs_exp = ~(8'd1 << chip[2:0]); // only the addressed chip low
			else
				spi_cs_exp = 8'hFF;

			send_frame(r, frame);
			collect_response(r, tbl_noresp[r], got, word, keep, last, live_seen);

			if (!tbl_noresp[r] && got) begin
				if (word !== tbl_exp[r]) begin
					$display("mismatch at %0t: row %0d response %h, expected %h",
						$time, r, word, tbl_exp[r]);
					mismatch_count++;
				end
				if (keep !== 4'hF || last !== 1'b1) begin
					$display("mismatch at %0t: row %0d keep %h last %b", $time, r, keep, last);
					mismatch_count++;
				end
			end
			if (live_seen !== tbl_live[r]) begin
				$display("mismatch at %0t: row %0d trigger live seen %b, expected %b",
					$time, r, live_seen, tbl_live[r]);
				mismatch_count++;
			end
			if (frame_byte(frame, 0) == 8'd3) begin
				if (frame_byte(frame, 7) == 8'd2)
					exp_count = 2;
				else if (frame_byte(frame, 7) == 8'd4)
					exp_count = 4;
				else
					exp_count = 3;
				if (spi_tx_count != exp_count || o_spi_cs !== 8'hFF
					|| o_miso_sel !== chip[2:0]) begin
					$display("mismatch at %0t: row %0d spi bytes %0d expected %0d, cs %h, miso %0d",
						$time, r, spi_tx_count, exp_count, o_spi_cs, o_miso_sel);
					mismatch_count++;
				end
			end
			check_settings(r, frame);
		end

		check_queued_reply(tbl_frame.size());

		$display("checks done: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== scope_cmd_top.f ====
source/scope_cmd_pkg.sv
source/cmd_frame_rx.sv
source/cmd_dispatch.sv
source/spi_transfer_seq.sv
source/resp_word_tx.sv
source/scope_cmd_top.sv
verification/tb_scope_cmd_top.sv

// ==== Bender.yml ====
package:
  name: scope_cmd

sources:
  - source/scope_cmd_pkg.sv
  - source/cmd_frame_rx.sv
  - source/cmd_dispatch.sv
  - source/spi_transfer_seq.sv
  - source/resp_word_tx.sv
  - source/scope_cmd_top.sv
  - target: test
    files:
      - verification/tb_scope_cmd_top.sv
